// File: source/shell_macros.svh
`ifndef SHELL_MACROS_SVH
`define SHELL_MACROS_SVH

// the APB window covers 16 word registers, so six byte-address bits are enough
`define SHELL_APB_AW 6
// every register is one 32-bit word
`define SHELL_DATA_W 32

// the host port sees a 1 GB window and drops the top two address bits
`define SHELL_HOST_AW 30
// device space and the PS DRAM are both 32-bit physical address spaces
`define SHELL_ADDR_W 32

// the device sees its DRAM starting at this address
`define SHELL_DEV_DRAM_BASE 32'h8000_0000
// offsets at or above 120 MiB fall outside the allocation and are flagged
`define SHELL_DRAM_LIMIT 32'h0780_0000

// bits 29:23 of a device DRAM address pick one of 128 regions of 8 MiB
`define SHELL_REGION_HI 29
`define SHELL_REGION_LO 23
`define SHELL_NUM_REGIONS 128

// the over-limit event counter saturates at its all-ones value
`define SHELL_LIMIT_CNT_W 8

`endif

// File: source/shell_pkg.sv
`include "shell_macros.svh"

package shell_pkg;

   // one APB data word as seen on pwdata and prdata
   typedef logic [`SHELL_DATA_W-1:0] shell_word_t;

   // byte offset inside the register window
   typedef logic [`SHELL_APB_AW-1:0] apb_addr_t;

   // address as it leaves the host port with the top bits already dropped
   typedef logic [`SHELL_HOST_AW-1:0] host_addr_t;

   // full device-space or PS DRAM physical address
   typedef logic [`SHELL_ADDR_W-1:0] dev_addr_t;

   // one bit per 8 MiB region, read back as four words with the low word first
   typedef logic [`SHELL_NUM_REGIONS-1:0] region_map_t;

   // index of a region inside the bitmap
   typedef logic [`SHELL_REGION_HI-`SHELL_REGION_LO:0] region_idx_t;

   // saturating count of over-limit DRAM requests
   typedef logic [`SHELL_LIMIT_CNT_W-1:0] limit_cnt_t;

   // register map of the control block
   // the status and profile words are read only
   typedef enum logic [`SHELL_APB_AW-1:0] {
      REG_CTRL      = 'h00,
      REG_ALLOC     = 'h04,
      REG_DRAM_BASE = 'h08,
      REG_STATUS    = 'h0C,
      REG_PROF0     = 'h10,
      REG_PROF1     = 'h14,
      REG_PROF2     = 'h18,
      REG_PROF3     = 'h1C
   } reg_offset_e;

endpackage

// File: source/shell_csr_if.sv
// control and status signals shared by the register block and the datapath
interface shell_csr_if;

   import shell_pkg::*;

   // physical base of the DRAM that the host allocated for the device
   dev_addr_t   dram_base;
   // high while the device is held in reset
   logic        dev_reset;
   // one-cycle strobe for each accepted request whose offset is past the allocation
   logic        over_limit_pulse;
   // one bit per 8 MiB region that the device has touched since the last run start
   region_map_t region_map;

   // the register block drives the control side and reads the status back
   modport regs
     (output  dram_base
      , output dev_reset
      , input  over_limit_pulse
      , input  region_map
      );

   // the rebaser needs the allocated base and reports requests past the limit
   modport rebase
     (input   dram_base
      , output over_limit_pulse
      );

   // the profiler clears under the device reset and owns the bitmap
   modport profiler
     (input   dev_reset
      , output region_map
      );

endinterface

// File: source/shell_regs.sv
`include "shell_macros.svh"

// APB register block of the shell
// it releases the device reset, holds the DRAM allocation and reports status
module shell_regs
  (input  logic                   aclk_i
   , input  logic                 reset_i

   // APB completer port with no wait states
   , input  shell_pkg::apb_addr_t   paddr_i
   , input  logic                   psel_i
   , input  logic                   penable_i
   , input  logic                   pwrite_i
   , input  shell_pkg::shell_word_t pwdata_i
   , output shell_pkg::shell_word_t prdata_o
   , output logic                   pready_o
   , output logic                   pslverr_o

   , shell_csr_if.regs              csr
   );

   import shell_pkg::*;

   // writable control registers
   logic        run_q;
   logic        alloc_q;
   dev_addr_t   dram_base_q;

   // over-limit status that only reset_i clears
   logic        limit_flag_q;
   limit_cnt_t  limit_cnt_q;

   // access phase and the decode results for the current offset
   logic        access;
   logic        wr_en;
   logic        mapped;
   logic        read_only;
   shell_word_t rdata;

   // the second cycle of a transfer is the access phase
   assign access = psel_i & penable_i;
   assign wr_en  = access & pwrite_i;

   // the block answers at once, so ready simply follows the select
   assign pready_o = psel_i;

   // offset decode and read mux
   // unmapped offsets fall to the default arm and read as zero
   always_comb
   begin
      rdata     = '0;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (paddr_i)
         REG_CTRL:
         begin
            rdata[0] = run_q;
         end
         REG_ALLOC:
         begin
            rdata[0] = alloc_q;
         end
         REG_DRAM_BASE:
         begin
            rdata = dram_base_q;
         end
         REG_STATUS:
         begin
            read_only = 1'b1;
            rdata[0]  = limit_flag_q;
            rdata[8 +: `SHELL_LIMIT_CNT_W] = limit_cnt_q;
         end
         REG_PROF0:
         begin
            read_only = 1'b1;
            rdata     = csr.region_map[0 * `SHELL_DATA_W +: `SHELL_DATA_W];
         end
         REG_PROF1:
         begin
            read_only = 1'b1;
            rdata     = csr.region_map[1 * `SHELL_DATA_W +: `SHELL_DATA_W];
         end
         REG_PROF2:
         begin
            read_only = 1'b1;
            rdata     = csr.region_map[2 * `SHELL_DATA_W +: `SHELL_DATA_W];
         end
         REG_PROF3:
         begin
            read_only = 1'b1;
            rdata     = csr.region_map[3 * `SHELL_DATA_W +: `SHELL_DATA_W];
         end
         default:
         begin
            mapped = 1'b0;
         end
      endcase
   end

   assign prdata_o = rdata;

   // an error is flagged for holes in the map and for writes to read-only words
   assign pslverr_o = access & (~mapped | (pwrite_i & read_only));

   // writes land on the edge that closes the access phase
   // read-only and unmapped offsets match no arm and change nothing
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         run_q       <= 1'b0;
         alloc_q     <= 1'b0;
         dram_base_q <= '0;
      end
      else if (wr_en)
      begin
         case (paddr_i)
            REG_CTRL:      run_q       <= pwdata_i[0];
            REG_ALLOC:     alloc_q     <= pwdata_i[0];
            REG_DRAM_BASE: dram_base_q <= pwdata_i;
            default:       ;
         endcase
      end
   end

   // each over-limit pulse sets the sticky flag and bumps the counter
   // the counter stops at its all-ones value instead of wrapping
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         limit_flag_q <= 1'b0;
         limit_cnt_q  <= '0;
      end
      else if (csr.over_limit_pulse)
      begin
         limit_flag_q <= 1'b1;
         if (limit_cnt_q != '1)
         begin
            limit_cnt_q <= limit_cnt_q + 1'b1;
         end
      end
   end

   // the device stays in reset during the shell reset and until the host sets run
   // this lets a new run start without reloading the bitstream
   assign csr.dev_reset = reset_i | ~run_q;
   assign csr.dram_base = dram_base_q;

   // a setup phase is always followed by an access phase that completes at once
   apb_no_wait_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      (psel_i && !penable_i) |=> (psel_i && penable_i && pready_o));

endmodule

// File: source/host_addr_xlate.sv
// host to device address translation
// host window 0x0xxx_xxxx lands on device DRAM at 0x8xxx_xxxx
// host window 0x2xxx_xxxx lands on device local space at 0x0xxx_xxxx
// windows with bit 28 set have no target and come back as errors
module host_addr_xlate
  (input  logic                   aclk_i
   , input  logic                 reset_i

   , input  shell_pkg::host_addr_t host_addr_i
   , input  logic                  host_valid_i

   , output shell_pkg::dev_addr_t  dev_addr_o
   , output logic                  dev_valid_o
   , output logic                  dev_err_o
   );

   import shell_pkg::*;

   dev_addr_t dev_addr_q;
   logic      dev_valid_q;
   logic      dev_err_q;
   logic      unmapped;

   // bit 28 selects the upper half of each 512 MB window, which has no target
   assign unmapped = host_addr_i[28];

   // the result shows up exactly one cycle after the request
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         dev_valid_q <= 1'b0;
         dev_err_q   <= 1'b0;
      end
      else
      begin
         dev_valid_q <= host_valid_i & ~unmapped;
         dev_err_q   <= host_valid_i & unmapped;
      end
   end

   // inverting bit 29 swaps the two windows and the top nibble keeps only that bit
   always_ff @(posedge aclk_i)
   begin
      if (host_valid_i)
      begin
         dev_addr_q <= {~host_addr_i[29], 3'b000, host_addr_i[27:0]};
      end
   end

   assign dev_addr_o  = dev_addr_q;
   assign dev_valid_o = dev_valid_q;
   assign dev_err_o   = dev_err_q;

   // valid and error are never raised together
   host_excl_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      !(dev_valid_o && dev_err_o));

endmodule

// File: source/dram_rebase.sv
`include "shell_macros.svh"

// one-entry DRAM request stage
// device DRAM addresses are moved into the buffer that the host allocated
module dram_rebase
  (input  logic                   aclk_i
   , input  logic                 reset_i

   // requests from the device side
   , input  shell_pkg::dev_addr_t dram_addr_i
   , input  logic                 dram_we_i
   , input  logic                 dram_valid_i
   , output logic                 dram_ready_o

   // requests toward the PS DRAM port
   , output shell_pkg::dev_addr_t mem_addr_o
   , output logic                 mem_we_o
   , output logic                 mem_valid_o
   , input  logic                 mem_ready_i

   // region touched by the accepted request
   , output shell_pkg::region_idx_t prof_idx_o
   , output logic                   prof_v_o

   , shell_csr_if.rebase          csr
   );

   import shell_pkg::*;

   logic      full_q;
   dev_addr_t addr_q;
   logic      we_q;

   logic      accept;
   dev_addr_t offset;
   dev_addr_t rebased;

   // the entry frees up in the same cycle the downstream port takes it
   assign dram_ready_o = ~full_q | mem_ready_i;
   assign accept       = dram_valid_i & dram_ready_o;

   // the device DRAM base has a single bit set, so the XOR removes it
   assign offset  = dram_addr_i ^ `SHELL_DEV_DRAM_BASE;
   // the sum wraps at 32 bits like the physical bus does
   assign rebased = offset + csr.dram_base;

   // the entry is filled on acceptance and drained on a downstream handshake
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         full_q <= 1'b0;
      end
      else if (accept)
      begin
         full_q <= 1'b1;
      end
      else if (mem_ready_i)
      begin
         full_q <= 1'b0;
      end
   end

   // the base is sampled with the request, so a later base write leaves it alone
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         addr_q <= rebased;
         we_q   <= dram_we_i;
      end
   end

   assign mem_addr_o  = addr_q;
   assign mem_we_o    = we_q;
   assign mem_valid_o = full_q;

   // an offset past the allocation still goes out but is counted by the register block
   assign csr.over_limit_pulse = accept & (offset >= `SHELL_DRAM_LIMIT);

   // the profiler looks at the device-side address of every accepted request
   assign prof_idx_o = dram_addr_i[`SHELL_REGION_HI:`SHELL_REGION_LO];
   assign prof_v_o   = accept;

   // a stalled request holds its address and direction until it is taken
   mem_hold_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      (mem_valid_o && !mem_ready_i) |=>
         (mem_valid_o && $stable(mem_addr_o) && $stable(mem_we_o)));

endmodule

// File: source/mem_profiler.sv
// memory use profiler
// each bit stands for one 8 MiB region of device DRAM
// the host reads the map to see how much memory a program touched
module mem_profiler
  (input  logic                    aclk_i

   // region index and strobe of each accepted DRAM request
   , input  shell_pkg::region_idx_t prof_idx_i
   , input  logic                   prof_v_i

   , shell_csr_if.profiler          csr
   );

   import shell_pkg::*;

   region_map_t map_q;

   // bits only ever get set while the device runs
   // the device reset also covers the shell reset, so one clear serves both
   always_ff @(posedge aclk_i)
   begin
      if (csr.dev_reset)
      begin
         map_q <= '0;
      end
      else if (prof_v_i)
      begin
         map_q[prof_idx_i] <= 1'b1;
      end
   end

   assign csr.region_map = map_q;

endmodule

// File: source/zynq_shell_top.sv
// programmable-logic shell between the host processor and the accelerator
// the host programs the register block over APB
// host accesses into the device window pass through the address translator
// device DRAM requests pass through the rebaser on their way to the PS memory
module zynq_shell_top
  (input  logic                     aclk_i
   , input  logic                   reset_i

   // reset of the accelerator, released by the run bit
   , output logic                   dev_reset_o

   // APB control port
   , input  shell_pkg::apb_addr_t   paddr_i
   , input  logic                   psel_i
   , input  logic                   penable_i
   , input  logic                   pwrite_i
   , input  shell_pkg::shell_word_t pwdata_i
   , output shell_pkg::shell_word_t prdata_o
   , output logic                   pready_o
   , output logic                   pslverr_o

   // host accesses into the device window
   , input  shell_pkg::host_addr_t  host_addr_i
   , input  logic                   host_valid_i
   , output shell_pkg::dev_addr_t   dev_addr_o
   , output logic                   dev_valid_o
   , output logic                   dev_err_o

   // device DRAM requests
   , input  shell_pkg::dev_addr_t   dram_addr_i
   , input  logic                   dram_we_i
   , input  logic                   dram_valid_i
   , output logic                   dram_ready_o

   // rebased requests toward the PS DRAM
   , output shell_pkg::dev_addr_t   mem_addr_o
   , output logic                   mem_we_o
   , output logic                   mem_valid_o
   , input  logic                   mem_ready_i
   );

   // accepted region index and strobe from the rebaser to the profiler
   shell_pkg::region_idx_t prof_idx;
   logic                   prof_v;

   // control and status shared between the register block and the datapath
   shell_csr_if csr_if ();

   shell_regs i_regs
     (.aclk_i    (aclk_i)
      ,.reset_i  (reset_i)
      ,.paddr_i  (paddr_i)
      ,.psel_i   (psel_i)
      ,.penable_i(penable_i)
      ,.pwrite_i (pwrite_i)
      ,.pwdata_i (pwdata_i)
      ,.prdata_o (prdata_o)
      ,.pready_o (pready_o)
      ,.pslverr_o(pslverr_o)
      ,.csr      (csr_if.regs)
      );

   host_addr_xlate i_host_xlate
     (.aclk_i       (aclk_i)
      ,.reset_i     (reset_i)
      ,.host_addr_i (host_addr_i)
      ,.host_valid_i(host_valid_i)
      ,.dev_addr_o  (dev_addr_o)
      ,.dev_valid_o (dev_valid_o)
      ,.dev_err_o   (dev_err_o)
      );

   // the rebaser keeps running across a device reset so that no request is cut off
   dram_rebase i_rebase
     (.aclk_i       (aclk_i)
      ,.reset_i     (reset_i)
      ,.dram_addr_i (dram_addr_i)
      ,.dram_we_i   (dram_we_i)
      ,.dram_valid_i(dram_valid_i)
      ,.dram_ready_o(dram_ready_o)
      ,.mem_addr_o  (mem_addr_o)
      ,.mem_we_o    (mem_we_o)
      ,.mem_valid_o (mem_valid_o)
      ,.mem_ready_i (mem_ready_i)
      ,.prof_idx_o  (prof_idx)
      ,.prof_v_o    (prof_v)
      ,.csr         (csr_if.rebase)
      );

   mem_profiler i_profiler
     (.aclk_i     (aclk_i)
      ,.prof_idx_i(prof_idx)
      ,.prof_v_i  (prof_v)
      ,.csr       (csr_if.profiler)
      );

   assign dev_reset_o = csr_if.dev_reset;

endmodule

// File: bench/tb_zynq_shell.sv
`include "shell_macros.svh"

// random-stimulus testbench of the programmable-logic shell
// a model in the testbench tracks the registers, the DRAM stage and the region map
module tb_zynq_shell;

   timeunit 1ns;
   timeprecision 1ps;

   import shell_pkg::*;

   // the test sequence needs roughly 4800 cycles
   localparam int CYCLE_LIMIT = 20000;

   logic        aclk;
   logic        reset;
   logic        dev_reset;
   apb_addr_t   paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   shell_word_t pwdata;
   shell_word_t prdata;
   logic        pready;
   logic        pslverr;
   host_addr_t  host_addr;
   logic        host_valid;
   dev_addr_t   dev_addr;
   logic        dev_valid;
   logic        dev_err;
   dev_addr_t   dram_addr;
   logic        dram_we;
   logic        dram_valid;
   logic        dram_ready;
   dev_addr_t   mem_addr;
   logic        mem_we;
   logic        mem_valid;
   logic        mem_ready;

   // model state
   logic        m_run;
   logic        m_alloc;
   dev_addr_t   m_base;
   logic        m_flag;
   limit_cnt_t  m_cnt;
   region_map_t m_map;
   // pending DRAM entry as {write flag, rebased address}
   logic [32:0] m_pending[$];

   logic [31:0] lfsr_state;
   int          errors;
   int          checks;

   zynq_shell_top i_dut
     (.aclk_i       (aclk)
      ,.reset_i     (reset)
      ,.dev_reset_o (dev_reset)
      ,.paddr_i     (paddr)
      ,.psel_i      (psel)
      ,.penable_i   (penable)
      ,.pwrite_i    (pwrite)
      ,.pwdata_i    (pwdata)
      ,.prdata_o    (prdata)
      ,.pready_o    (pready)
      ,.pslverr_o   (pslverr)
      ,.host_addr_i (host_addr)
      ,.host_valid_i(host_valid)
      ,.dev_addr_o  (dev_addr)
      ,.dev_valid_o (dev_valid)
      ,.dev_err_o   (dev_err)
      ,.dram_addr_i (dram_addr)
      ,.dram_we_i   (dram_we)
      ,.dram_valid_i(dram_valid)
      ,.dram_ready_o(dram_ready)
      ,.mem_addr_o  (mem_addr)
      ,.mem_we_o    (mem_we)
      ,.mem_valid_o (mem_valid)
      ,.mem_ready_i (mem_ready)
      );

   initial
   begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   // one shift of a right-shifting Galois LFSR
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
   endfunction

   // every bit handed out costs one LFSR step
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("MISMATCH %s expected %h got %h at %0t", name, exp, act, $time);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("ERROR: %s at %0t", what, $time);
      errors++;
   endtask

   // expected read data and error for one offset, taken from the shadow registers
   function automatic void read_expect(input apb_addr_t a, output shell_word_t d,
                                       output logic err);
      d   = '0;
      err = 1'b0;
      case (a)
         REG_CTRL:      d[0] = m_run;
         REG_ALLOC:     d[0] = m_alloc;
         REG_DRAM_BASE: d = m_base;
         REG_STATUS:    d = {16'h0000, m_cnt, 7'b0000000, m_flag};
         REG_PROF0:     d = m_map[31:0];
         REG_PROF1:     d = m_map[63:32];
         REG_PROF2:     d = m_map[95:64];
         REG_PROF3:     d = m_map[127:96];
         default:       err = 1'b1;
      endcase
   endfunction

   // writes into holes or into the status and profile words are refused
   function automatic logic write_err(input apb_addr_t a);
      return !(a == REG_CTRL || a == REG_ALLOC || a == REG_DRAM_BASE);
   endfunction

   task automatic model_write(input apb_addr_t a, input shell_word_t d);
      case (a)
         REG_CTRL:      m_run = d[0];
         REG_ALLOC:     m_alloc = d[0];
         REG_DRAM_BASE: m_base = d;
         default:       ;
      endcase
      // a cleared run bit holds the profiler in reset
      if (!m_run) m_map = '0;
   endtask

   task automatic apb_write(input apb_addr_t a, input shell_word_t d);
      logic exp_err;
      exp_err = write_err(a);
      @(posedge aclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= a;
      pwdata  <= d;
      @(posedge aclk);
      penable <= 1'b1;
      @(negedge aclk);
      checks++;
      if (pready !== 1'b1) report_failure("pready_o low in the access phase of a write");
      if (pslverr !== exp_err) report_mismatch("pslverr_o", exp_err, pslverr);
      // the write lands on this edge
      @(posedge aclk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      model_write(a, d);
      @(negedge aclk);
      if (dev_reset !== ~m_run) report_mismatch("dev_reset_o", ~m_run, dev_reset);
   endtask

   task automatic apb_read(input apb_addr_t a);
      shell_word_t exp_d;
      logic        exp_err;
      read_expect(a, exp_d, exp_err);
      @(posedge aclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= a;
      @(posedge aclk);
      penable <= 1'b1;
      @(negedge aclk);
      checks++;
      if (pready !== 1'b1) report_failure("pready_o low in the access phase of a read");
      if (prdata !== exp_d) report_mismatch("prdata_o", exp_d, prdata);
      if (pslverr !== exp_err) report_mismatch("pslverr_o", exp_err, pslverr);
      if (dev_reset !== ~m_run) report_mismatch("dev_reset_o", ~m_run, dev_reset);
      @(posedge aclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // each host request is answered on the cycle after it is driven
   task automatic host_translation(input int n);
      host_addr_t cur_addr;
      logic       cur_valid;
      host_addr_t prev_addr;
      logic       prev_valid;
      dev_addr_t  exp_addr;
      int         i;
      prev_addr  = '0;
      prev_valid = 1'b0;
      for (i = 0; i <= n; i++)
      begin
         cur_addr  = rand_bits(30);
         cur_valid = (i < n) ? rand_bits(1) : 1'b0;
         @(posedge aclk);
         host_addr  <= cur_addr;
         host_valid <= cur_valid;
         @(negedge aclk);
         checks++;
         if (dev_valid !== (prev_valid & ~prev_addr[28]))
            report_mismatch("dev_valid_o", prev_valid & ~prev_addr[28], dev_valid);
         if (dev_err !== (prev_valid & prev_addr[28]))
            report_mismatch("dev_err_o", prev_valid & prev_addr[28], dev_err);
         // the low window moves up by 0x8000_0000 and the 0x2xxx_xxxx window moves down to zero
         exp_addr = prev_addr[29] ? {2'b00, prev_addr} - 32'h2000_0000
                                  : {2'b00, prev_addr} + 32'h8000_0000;
         if (prev_valid && !prev_addr[28] && dev_addr !== exp_addr)
            report_mismatch("dev_addr_o", exp_addr, dev_addr);
         prev_addr  = cur_addr;
         prev_valid = cur_valid;
      end
      @(posedge aclk);
      host_valid <= 1'b0;
   endtask

   // random DRAM requests under random back-pressure, then a drain with ready held high
   task automatic dram_traffic(input int n);
      dev_addr_t   a;
      dev_addr_t   offset;
      logic [31:0] r;
      logic [32:0] front;
      logic        v;
      logic        we;
      logic        rdy;
      logic        exp_ready;
      int          i;
      a = '0;
      i = 0;
      while (i < n || m_pending.size() != 0)
      begin
         v   = 1'b0;
         we  = 1'b0;
         rdy = 1'b1;
         if (i < n)
         begin
            v   = rand_bits(1);
            we  = rand_bits(1);
            rdy = (rand_bits(2) != 0);
            // about half the requests are anywhere, the rest inside the first 128 MiB
            r = rand_bits(27);
            a = (rand_bits(2) < 2) ? rand_bits(32) : {5'b10000, r[26:0]};
         end
         @(posedge aclk);
         dram_valid <= v;
         dram_addr  <= a;
         dram_we    <= we;
         mem_ready  <= rdy;
         @(negedge aclk);
         checks++;
         exp_ready = (m_pending.size() == 0) | rdy;
         if (dram_ready !== exp_ready) report_mismatch("dram_ready_o", exp_ready, dram_ready);
         if (mem_valid !== (m_pending.size() != 0))
            report_mismatch("mem_valid_o", m_pending.size() != 0, mem_valid);
         // comparing with the queue head every cycle also checks a stall holds its value
         if (m_pending.size() != 0)
         begin
            front = m_pending[0];
            if (mem_addr !== front[31:0]) report_mismatch("mem_addr_o", front[31:0], mem_addr);
            if (mem_we !== front[32]) report_mismatch("mem_we_o", front[32], mem_we);
            if (rdy) void'(m_pending.pop_front());
         end
         if (v && exp_ready)
         begin
            offset = a ^ `SHELL_DEV_DRAM_BASE;
            m_pending.push_back({we, offset + m_base});
            if (offset >= `SHELL_DRAM_LIMIT)
            begin
               m_flag = 1'b1;
               if (m_cnt != 8'hFF) m_cnt = m_cnt + 1'b1;
            end
            if (m_run) m_map[a[`SHELL_REGION_HI:`SHELL_REGION_LO]] = 1'b1;
         end
         i++;
      end
   endtask

   task automatic status_and_map_readback();
      int k;
      apb_read(REG_STATUS);
      for (k = 0; k < 4; k++) apb_read(6'h10 + 6'(4 * k));
   endtask

   // watchdog so that a stuck handshake cannot hang the run
   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge aclk);
         cycles++;
      end
      $display("ERROR: run did not finish within %0d cycles, errors: %0d", CYCLE_LIMIT, errors);
      $display("Verification failed");
      $finish;
   end

   initial
   begin
      apb_addr_t   a;
      logic [31:0] r;
      int          k;
      reset      = 1'b1;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      host_addr  = '0;
      host_valid = 1'b0;
      dram_addr  = '0;
      dram_we    = 1'b0;
      dram_valid = 1'b0;
      mem_ready  = 1'b0;
      m_run      = 1'b0;
      m_alloc    = 1'b0;
      m_base     = '0;
      m_flag     = 1'b0;
      m_cnt      = '0;
      m_map      = '0;
      lfsr_state = 32'ha38;
      errors     = 0;
      checks     = 0;

      repeat (5) @(posedge aclk);
      reset <= 1'b0;
      @(negedge aclk);
      if (dev_reset !== 1'b1) report_mismatch("dev_reset_o", 1'b1, dev_reset);
      if (dev_valid !== 1'b0) report_mismatch("dev_valid_o", 1'b0, dev_valid);
      if (dev_err !== 1'b0) report_mismatch("dev_err_o", 1'b0, dev_err);
      if (mem_valid !== 1'b0) report_mismatch("mem_valid_o", 1'b0, mem_valid);
      for (k = 0; k < 8; k++) apb_read(6'(4 * k));

      // random register traffic, every write is read back straight away
      repeat (300)
      begin
         r = rand_bits(3);
         case (r[2:0])
            3'd0:    a = REG_CTRL;
            3'd1:    a = REG_ALLOC;
            3'd2:    a = REG_DRAM_BASE;
            3'd3:    a = REG_STATUS;
            3'd4:    a = 6'h10 + {rand_bits(2) & 32'h3, 2'b00};
            default: a = rand_bits(6);
         endcase
         if (rand_bits(1)) apb_write(a, rand_bits(32));
         apb_read(a);
      end

      host_translation(500);

      apb_write(REG_CTRL, 32'h1);
      apb_write(REG_ALLOC, 32'h1);
      apb_write(REG_DRAM_BASE, rand_bits(32));
      dram_traffic(300);
      status_and_map_readback();

      apb_write(REG_DRAM_BASE, rand_bits(32));
      dram_traffic(2000);
      status_and_map_readback();
      if (m_cnt != 8'hFF) report_failure("over-limit counter never reached saturation");

      // status survives a write attempt, the map clears across a run toggle
      apb_write(REG_STATUS, rand_bits(32));
      apb_read(REG_STATUS);
      apb_write(REG_CTRL, 32'h0);
      apb_write(REG_CTRL, 32'h1);
      status_and_map_readback();

      @(posedge aclk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+source
source/shell_pkg.sv
source/shell_csr_if.sv
source/shell_regs.sv
source/host_addr_xlate.sv
source/dram_rebase.sv
source/mem_profiler.sv
source/zynq_shell_top.sv
bench/tb_zynq_shell.sv
